// File: common/rv32m_pkg.sv
`default_nettype none

package rv32m_pkg;

  // datapath width, one RV32 word
  localparam int XLEN = 32;

  // completion buffer depth, tag indexes one entry
  localparam int CB_ENTRIES = 8;
  localparam int TAG_W = $clog2(CB_ENTRIES);  // 3 bits for 8 entries

  // one quotient bit per step, so a full word takes XLEN steps
  localparam int DIV_STEPS = XLEN;

  typedef logic [XLEN-1:0]  word_t;
  typedef logic [TAG_W-1:0] cb_tag_t;

  // M-extension ops, funct3 order
  // bit 2 clear is the multiply class, set is the divide class
  typedef enum logic [2:0] {
    MUL    = 3'b000,  // low word, sign does not matter
    MULH   = 3'b001,  // high word, signed x signed
    MULHSU = 3'b010,  // high word, signed x unsigned
    MULHU  = 3'b011,  // high word, unsigned x unsigned
    DIV    = 3'b100,  // signed quotient
    DIVU   = 3'b101,  // unsigned quotient
    REM    = 3'b110,  // signed remainder
    REMU   = 3'b111   // unsigned remainder
  } muldiv_op_t;

  // shared by the divider core and the divide wrapper
  typedef enum logic [1:0] {
    IDLE = 2'b00,  // waiting for start
    CALC = 2'b01,  // iterating
    HOLD = 2'b10   // result ready
  } div_state_t;

endpackage

`default_nettype wire

// File: multiply/multiply_unit.sv
`timescale 1ns/100ps
`default_nettype none

module multiply_unit (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               start,
  input  rv32m_pkg::muldiv_op_t op,
  input  rv32m_pkg::word_t   rs1_data,
  input  rv32m_pkg::word_t   rs2_data,
  input  rv32m_pkg::cb_tag_t tag,
  output logic               req,
  output rv32m_pkg::cb_tag_t res_tag,
  output rv32m_pkg::word_t   res_data
);

  import rv32m_pkg::*;

  logic            rs1_signed, rs2_signed;  // operand treatment per op

  // stage one, extended operands
  logic            valid_s1;
  muldiv_op_t      op_s1;
  cb_tag_t         tag_s1;
  logic [XLEN:0]   a_s1, b_s1;  // 33 bits, msb is the extension

  // stage two, full product
  logic            valid_s2;
  muldiv_op_t      op_s2;
  cb_tag_t         tag_s2;
  logic [2*XLEN+1:0] prod_s2;   // 33 x 33 gives 66 bits

  // which operands are read as two's complement
  always_comb begin
    case (op)
      MUL:     begin rs1_signed = 1'b1; rs2_signed = 1'b1; end  // low word same either way
      MULH:    begin rs1_signed = 1'b1; rs2_signed = 1'b1; end
      MULHSU:  begin rs1_signed = 1'b1; rs2_signed = 1'b0; end
      default: begin rs1_signed = 1'b0; rs2_signed = 1'b0; end  // MULHU
    endcase
  end

  // valid bits walk the pipe, never stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= start;
      valid_s2 <= valid_s1;
    end
  end

  // payload only moves with a valid op
  always_ff @(posedge CLK) begin
    if (start) begin
      op_s1  <= op;
      tag_s1 <= tag;
      a_s1   <= {rs1_signed & rs1_data[XLEN-1], rs1_data};
      b_s1   <= {rs2_signed & rs2_data[XLEN-1], rs2_data};
    end
    if (valid_s1) begin
      op_s2   <= op_s1;
      tag_s2  <= tag_s1;
      prod_s2 <= $signed(a_s1) * $signed(b_s1);  // one signed multiply covers all four ops
    end
  end

  assign req     = valid_s2;
  assign res_tag = tag_s2;
  // low word for MUL, high word otherwise
  assign res_data = (op_s2 == MUL) ? prod_s2[XLEN-1:0] : prod_s2[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: divide/divider.sv
`timescale 1ns/100ps
`default_nettype none

module divider (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  rv32m_pkg::word_t dividend,
  input  rv32m_pkg::word_t divisor,
  output logic             done,
  output rv32m_pkg::word_t quotient,
  output rv32m_pkg::word_t remainder
);

  import rv32m_pkg::*;

  div_state_t state, next_state;
  logic [$clog2(DIV_STEPS)-1:0] count;  // step index, 0 .. DIV_STEPS-1
  logic       last_step;

  word_t      quo_q;   // dividend shifts out the top, quotient bits shift in
  word_t      rem_q;   // partial remainder, always below the divisor
  word_t      dvsr_q;  // divisor held for the whole run

  logic [XLEN:0]   shifted;  // partial remainder with next dividend bit
  logic [XLEN+1:0] diff;     // trial subtract, msb is the borrow
  logic            fits;     // divisor goes in, quotient bit is one

  // trial subtract for the current step
  always_comb begin
    shifted = {rem_q, quo_q[XLEN-1]};
    diff    = {1'b0, shifted} - {2'b00, dvsr_q};
    fits    = ~diff[XLEN+1];
  end

  assign last_step = (count == $bits(count)'(DIV_STEPS - 1));

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (start) next_state = CALC;
      CALC:    if (last_step) next_state = HOLD;
      HOLD:    next_state = IDLE;  // done lasts one cycle
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      count <= '0;
    end else begin
      state <= next_state;
      if (state == IDLE) count <= '0;
      else if (state == CALC) count <= count + 1'b1;
    end
  end

  // datapath, load on start then one bit per CALC cycle
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      quo_q  <= dividend;
      rem_q  <= '0;
      dvsr_q <= divisor;
    end else if (state == CALC) begin
      quo_q <= {quo_q[XLEN-2:0], fits};
      if (fits) rem_q <= diff[XLEN-1:0];  // keep the difference
      else rem_q <= shifted[XLEN-1:0];    // restore
    end
  end

  assign done      = (state == HOLD);
  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

`default_nettype wire

// File: divide/divide_unit.sv
`timescale 1ns/100ps
`default_nettype none

module divide_unit (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               start,
  input  rv32m_pkg::muldiv_op_t op,
  input  rv32m_pkg::word_t   rs1_data,
  input  rv32m_pkg::word_t   rs2_data,
  input  rv32m_pkg::cb_tag_t tag,
  input  logic               gnt,
  output logic               busy,
  output logic               req,
  output rv32m_pkg::cb_tag_t res_tag,
  output rv32m_pkg::word_t   res_data
);

  import rv32m_pkg::*;

  div_state_t state;
  logic       accept;      // start taken in IDLE
  logic       is_signed, is_rem;
  logic       div_zero, overflow, special;
  word_t      special_val;  // architectural result for the bypass cases
  word_t      rs1_abs, rs2_abs;
  logic       core_start, core_done;
  word_t      core_quo, core_rem;
  word_t      quo_fix, rem_fix;

  muldiv_op_t op_q;
  cb_tag_t    tag_q;
  logic       quo_neg_q;   // operand signs differ
  logic       rem_neg_q;   // dividend was negative
  word_t      res_q;

  assign accept = start && (state == IDLE);

  // decode and special cases on the raw issue operands
  always_comb begin
    is_signed = (op == DIV) || (op == REM);
    is_rem    = (op == REM) || (op == REMU);
    div_zero  = (rs2_data == '0);
    overflow  = is_signed && (rs1_data == {1'b1, {(XLEN-1){1'b0}}}) && (rs2_data == '1);
    special   = div_zero || overflow;
    if (div_zero) special_val = is_rem ? rs1_data : '1;  // rem = dividend, quo = all ones
    else special_val = is_rem ? '0 : {1'b1, {(XLEN-1){1'b0}}};  // overflow case
    rs1_abs = (is_signed && rs1_data[XLEN-1]) ? -rs1_data : rs1_data;
    rs2_abs = (is_signed && rs2_data[XLEN-1]) ? -rs2_data : rs2_data;
  end

  assign core_start = accept && !special;

  divider u_divider (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (core_start),
    .dividend  (rs1_abs),
    .divisor   (rs2_abs),
    .done      (core_done),
    .quotient  (core_quo),
    .remainder (core_rem)
  );

  // sign fix on the magnitudes from the core
  assign quo_fix = quo_neg_q ? -core_quo : core_quo;
  assign rem_fix = rem_neg_q ? -core_rem : core_rem;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (accept) state <= special ? HOLD : CALC;  // bypass goes straight to HOLD
        CALC:    if (core_done) state <= HOLD;
        HOLD:    if (gnt) state <= IDLE;  // result taken by the bus
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      op_q      <= op;
      tag_q     <= tag;
      quo_neg_q <= is_signed && (rs1_data[XLEN-1] ^ rs2_data[XLEN-1]);
      rem_neg_q <= is_signed && rs1_data[XLEN-1];
      if (special) res_q <= special_val;
    end else if (state == CALC && core_done) begin
      res_q <= ((op_q == REM) || (op_q == REMU)) ? rem_fix : quo_fix;
    end
  end

  assign busy     = (state != IDLE);
  assign req      = (state == HOLD);  // held until gnt
  assign res_tag  = tag_q;
  assign res_data = res_q;

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter (
  input  logic               mul_req,
  input  rv32m_pkg::cb_tag_t mul_tag,
  input  rv32m_pkg::word_t   mul_data,
  input  logic               div_req,
  input  rv32m_pkg::cb_tag_t div_tag,
  input  rv32m_pkg::word_t   div_data,
  output logic               div_gnt,
  output logic               wb_valid,
  output rv32m_pkg::cb_tag_t wb_tag,
  output rv32m_pkg::word_t   wb_data
);

  // multiply cannot stall so it always wins
  // divide only gets the bus on a cycle without a multiply result
  always_comb begin
    div_gnt  = div_req && !mul_req;
    wb_valid = mul_req || div_req;
    if (mul_req) begin
      wb_tag  = mul_tag;
      wb_data = mul_data;
    end else begin
      wb_tag  = div_tag;   // don't care when div_req is low too
      wb_data = div_data;
    end
  end

endmodule

`default_nettype wire

// File: design/muldiv_top.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_top (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               issue,
  input  rv32m_pkg::muldiv_op_t op,
  input  rv32m_pkg::word_t   rs1_data,
  input  rv32m_pkg::word_t   rs2_data,
  input  rv32m_pkg::cb_tag_t tag,
  output logic               div_busy,
  output logic               wb_valid,
  output rv32m_pkg::cb_tag_t wb_tag,
  output rv32m_pkg::word_t   wb_data
);

  import rv32m_pkg::*;

  logic    is_mul_op;
  logic    mul_start, div_start;
  logic    mul_req;
  cb_tag_t mul_tag;
  word_t   mul_data;
  logic    div_req, div_gnt;
  cb_tag_t div_tag;
  word_t   div_data;

  // op class decode, done once here
  assign is_mul_op = (op == MUL) || (op == MULH) || (op == MULHSU) || (op == MULHU);
  assign mul_start = issue && is_mul_op;
  assign div_start = issue && !is_mul_op;  // DIV .. REMU

  multiply_unit u_multiply_unit (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (mul_start),
    .op       (op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .tag      (tag),
    .req      (mul_req),
    .res_tag  (mul_tag),
    .res_data (mul_data)
  );

  divide_unit u_divide_unit (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (div_start),
    .op       (op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .tag      (tag),
    .gnt      (div_gnt),
    .busy     (div_busy),  // issuer holds off divides while high
    .req      (div_req),
    .res_tag  (div_tag),
    .res_data (div_data)
  );

  wb_arbiter u_wb_arbiter (
    .mul_req  (mul_req),
    .mul_tag  (mul_tag),
    .mul_data (mul_data),
    .div_req  (div_req),
    .div_tag  (div_tag),
    .div_data (div_data),
    .div_gnt  (div_gnt),
    .wb_valid (wb_valid),
    .wb_tag   (wb_tag),
    .wb_data  (wb_data)
  );

endmodule

`default_nettype wire

// File: tb/muldiv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;

  import rv32m_pkg::*;

  localparam int          CLK_PERIOD     = 100;
  localparam int          RESET_CYCLES   = 5;
  localparam int          MUL_LAT        = 2;    // issue negedge to sampled writeback, in cycles
  localparam int          N_RAND         = 300;
  localparam int          TIMEOUT_MARGIN = 200;
  localparam logic [31:0] SEED           = 32'h465654c6;

  logic       CLK, nRST;
  logic       issue;
  muldiv_op_t op;
  word_t      rs1_data, rs2_data;
  cb_tag_t    tag;
  logic       div_busy;
  logic       wb_valid;
  cb_tag_t    wb_tag;
  word_t      wb_data;

  // directed table, one entry per row
  string      row_name [$];
  muldiv_op_t row_op [$];
  word_t      row_a [$];
  word_t      row_b [$];
  word_t      row_exp [$];

  // scoreboard, indexed by tag
  logic       outstanding [CB_ENTRIES];
  word_t      exp_data [CB_ENTRIES];
  string      name_of [CB_ENTRIES];
  cb_tag_t    next_tag;
  int         pending_cnt;
  cb_tag_t    mul_tag_q [$];  // multiplies in issue order
  int         mul_due_q [$];  // cycle each one must show up
  logic       div_pending;    // one divide at a time
  cb_tag_t    div_tag_exp;
  int         div_issue_cycle;
  int         cycle;
  int         cycle_limit;

  muldiv_top i_dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .issue    (issue),
    .op       (op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .tag      (tag),
    .div_busy (div_busy),
    .wb_valid (wb_valid),
    .wb_tag   (wb_tag),
    .wb_data  (wb_data)
  );

  always #(CLK_PERIOD/2) CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
      abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_tag(input string name, input cb_tag_t exp, input cb_tag_t act);
    if (act !== exp)
      abort_run($sformatf("Error: %s expected tag %0d actual tag %0d", name, exp, act));
  endtask

  // reference results straight from the M-extension rules
  function automatic word_t ref_result(muldiv_op_t f_op, word_t a, word_t b);
    logic signed [2*XLEN-1:0] sa, sb, sres;
    logic [2*XLEN-1:0]        ua, ub, ures;
    logic                     ovf;
    sa   = {{XLEN{a[XLEN-1]}}, a};
    sb   = {{XLEN{b[XLEN-1]}}, b};
    ua   = {{XLEN{1'b0}}, a};
    ub   = {{XLEN{1'b0}}, b};
    ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);  // most negative / -1
    sres = '0;
    ures = '0;
    case (f_op)
      MUL:    ures = ua * ub;
      MULH:   sres = sa * sb;
      MULHSU: sres = sa * $signed(ub);  // ub top half is zero, stays positive
      MULHU:  ures = ua * ub;
      DIV: begin
        if (b == '0) sres = '1;
        else if (ovf) sres = sa;  // most negative comes back
        else sres = sa / sb;      // truncates toward zero
      end
      DIVU:   ures = (b == '0) ? '1 : ua / ub;
      REM: begin
        if (b == '0) sres = sa;
        else if (ovf) sres = '0;
        else sres = sa % sb;  // sign of dividend
      end
      default: ures = (b == '0) ? ua : ua % ub;            // REMU
    endcase
    case (f_op)
      MUL, DIVU, REMU: return ures[XLEN-1:0];
      MULHU:           return ures[2*XLEN-1:XLEN];
      MULH, MULHSU:    return sres[2*XLEN-1:XLEN];
      default:         return sres[XLEN-1:0];
    endcase
  endfunction

  // biased toward the corner values
  function automatic word_t rand_operand();
    int unsigned pick;
    pick = $urandom_range(0, 7);
    case (pick)
      0:       return '0;
      1:       return {1'b1, {(XLEN-1){1'b0}}};
      2:       return '1;
      3:       return word_t'($urandom_range(1, 20));
      default: return word_t'($urandom);
    endcase
  endfunction

  task automatic add_row(input string name, input muldiv_op_t r_op, input word_t a,
                         input word_t b, input word_t exp);
    row_name.push_back(name);
    row_op.push_back(r_op);
    row_a.push_back(a);
    row_b.push_back(b);
    row_exp.push_back(exp);
  endtask

  task automatic build_table();
    add_row("mul_pos",      MUL,    32'd7,        32'd6,        32'h0000002a);
    add_row("mul_neg",      MUL,    32'hfffffffd, 32'd5,        32'hfffffff1);
    add_row("mulh_neg",     MULH,   32'hfffffffe, 32'd3,        32'hffffffff);
    add_row("mulh_big",     MULH,   32'h80000000, 32'h80000000, 32'h40000000);
    add_row("mulhsu_neg",   MULHSU, 32'hffffffff, 32'hffffffff, 32'hffffffff);
    add_row("mulhsu_pos",   MULHSU, 32'd2,        32'h80000000, 32'h00000001);
    add_row("mulhu_max",    MULHU,  32'hffffffff, 32'hffffffff, 32'hfffffffe);
    add_row("mul_b2b",      MUL,    32'h12345678, 32'h10,       32'h23456780);
    add_row("mulhu_b2b",    MULHU,  32'h12345678, 32'h10,       32'h00000001);
    add_row("div_mixed",    DIV,    32'hfffffff9, 32'd2,        32'hfffffffd);
    add_row("mul_in_div",   MUL,    32'd3,        32'd3,        32'h00000009);  // while divide runs
    add_row("rem_mixed",    REM,    32'hfffffff9, 32'd2,        32'hffffffff);
    add_row("div_negneg",   DIV,    32'hfffffff9, 32'hfffffffe, 32'h00000003);
    add_row("rem_posneg",   REM,    32'd7,        32'hfffffffe, 32'h00000001);
    add_row("divu_big",     DIVU,   32'hfffffff9, 32'd2,        32'h7ffffffc);
    add_row("remu_big",     REMU,   32'hfffffff9, 32'd2,        32'h00000001);
    add_row("divu_small",   DIVU,   32'd100,      32'd7,        32'h0000000e);
    add_row("remu_small",   REMU,   32'd100,      32'd7,        32'h00000002);
    add_row("div_by_zero",  DIV,    32'h12345678, 32'd0,        32'hffffffff);
    add_row("divu_by_zero", DIVU,   32'd5,        32'd0,        32'hffffffff);
    add_row("rem_by_zero",  REM,    32'hfffffff9, 32'd0,        32'hfffffff9);
    add_row("remu_by_zero", REMU,   32'h12345678, 32'd0,        32'h12345678);
    add_row("div_ovf",      DIV,    32'h80000000, 32'hffffffff, 32'h80000000);
    add_row("rem_ovf",      REM,    32'h80000000, 32'hffffffff, 32'h00000000);
    add_row("mul_gap",      MUL,    32'd0,        32'd9,        32'h00000000);
    add_row("mul_collide",  MUL,    32'h100,      32'h100,      32'h00010000);
    add_row("divz_collide", DIVU,   32'd9,        32'd0,        32'hffffffff);  // loses to mul
  endtask

  // called on a falling edge, returns on the next one
  task automatic issue_op(input string name, input muldiv_op_t r_op, input word_t a,
                          input word_t b, input word_t exp);
    cb_tag_t t;
    logic    is_div;
    is_div = (r_op == DIV) || (r_op == DIVU) || (r_op == REM) || (r_op == REMU);
    if (is_div)
      while (div_busy || div_pending) @(negedge CLK);
    while (outstanding[next_tag]) @(negedge CLK);  // tag still in flight
    t        = next_tag;
    next_tag = next_tag + 1'b1;  // wraps
    outstanding[t] = 1'b1;
    exp_data[t]    = exp;
    name_of[t]     = name;
    pending_cnt++;
    if (is_div) begin
      div_pending     = 1'b1;
      div_tag_exp     = t;
      div_issue_cycle = cycle;
    end else begin
      mul_tag_q.push_back(t);
      mul_due_q.push_back(cycle + MUL_LAT);
    end
    issue    = 1'b1;
    op       = r_op;
    rs1_data = a;
    rs2_data = b;
    tag      = t;
    @(negedge CLK);
    issue = 1'b0;
  endtask

  // bus tag must be in flight, then match the one due
  task automatic retire_tag(input cb_tag_t exp_tag);
    if (outstanding[wb_tag] !== 1'b1) begin
      abort_run($sformatf("writeback with tag %0d that is not outstanding", wb_tag));
    end else begin
      check_tag(name_of[exp_tag], exp_tag, wb_tag);
      check_word(name_of[exp_tag], exp_data[exp_tag], wb_data);
      outstanding[exp_tag] = 1'b0;
      pending_cnt--;
    end
  endtask

  // pre-edge values of the bus, registered outputs only
  always @(posedge CLK) begin : monitor
    cb_tag_t exp_tag;
    if (nRST) begin
      if (div_pending && cycle > div_issue_cycle && div_busy !== 1'b1)
        abort_run("div_busy went low while a divide result was still outstanding");
      else if (!div_pending && div_busy !== 1'b0)
        abort_run("div_busy is high with no divide outstanding");
      else if (mul_due_q.size() > 0 && mul_due_q[0] == cycle) begin
        exp_tag = mul_tag_q.pop_front();
        void'(mul_due_q.pop_front());
        if (wb_valid !== 1'b1)
          abort_run($sformatf("multiply result for tag %0d missing on its cycle", exp_tag));
        else
          retire_tag(exp_tag);  // multiply must win the bus
      end else if (wb_valid === 1'b1) begin
        if (!div_pending)
          abort_run($sformatf("writeback with tag %0d while nothing is due", wb_tag));
        else begin
          retire_tag(div_tag_exp);
          div_pending = 1'b0;
        end
      end else if (wb_valid !== 1'b0)
        abort_run("wb_valid is unknown");
    end
    cycle++;
    if (cycle >= cycle_limit)
      abort_run($sformatf("timeout after %0d cycles with %0d results outstanding",
                          cycle, pending_cnt));
  end

  initial begin : driver
    word_t      a, b;
    muldiv_op_t rop;
    CLK         = 1'b0;
    nRST        = 1'b0;
    issue       = 1'b0;
    op          = MUL;
    rs1_data    = '0;
    rs2_data    = '0;
    tag         = '0;
    next_tag    = '0;
    pending_cnt = 0;
    div_pending = 1'b0;
    div_tag_exp = '0;
    div_issue_cycle = 0;
    cycle       = 0;
    for (int i = 0; i < CB_ENTRIES; i++) outstanding[i] = 1'b0;
    void'($urandom(SEED));
    build_table();
    cycle_limit = (row_name.size() + N_RAND) * (DIV_STEPS + 4) + TIMEOUT_MARGIN;

    repeat (RESET_CYCLES) @(negedge CLK);
    nRST = 1'b1;
    if (wb_valid !== 1'b0 || div_busy !== 1'b0)
      abort_run("wb_valid or div_busy not low after reset");

    // directed rows, back to back where the ops allow
    for (int i = 0; i < row_name.size(); i++)
      issue_op(row_name[i], row_op[i], row_a[i], row_b[i], row_exp[i]);

    // random mix, expected from the model
    for (int i = 0; i < N_RAND; i++) begin
      rop = muldiv_op_t'($urandom_range(0, 7));
      a   = rand_operand();
      b   = rand_operand();
      issue_op($sformatf("rand_%0d", i), rop, a, b, ref_result(rop, a, b));
      if ($urandom_range(0, 3) == 0) @(negedge CLK);  // idle gap now and then
    end

    while (pending_cnt != 0) @(negedge CLK);
    repeat (4) @(negedge CLK);  // quiet bus afterwards
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
common/rv32m_pkg.sv
multiply/multiply_unit.sv
divide/divider.sv
divide/divide_unit.sv
design/wb_arbiter.sv
design/muldiv_top.sv
tb/muldiv_tb.sv

// File: Bender.yml
package:
  name: muldiv

sources:
  - common/rv32m_pkg.sv
  - multiply/multiply_unit.sv
  - divide/divider.sv
  - divide/divide_unit.sv
  - design/wb_arbiter.sv
  - design/muldiv_top.sv
  - target: test
    files:
      - tb/muldiv_tb.sv
